/* hdl/la_decode_pkg.sv */
package la_decode_pkg;

    localparam int ALU_WIDTH       = 8;
    localparam int ALU_SEL_WIDTH   = 3;
    localparam int EXC_CAUSE_WIDTH = 6;

    // 3R and 2R-immediate opcodes, inst[31:15]
    localparam logic [16:0] ADDW_OPCODE    = 17'h00020;
    localparam logic [16:0] SUBW_OPCODE    = 17'h00022;
    localparam logic [16:0] SLT_OPCODE     = 17'h00024;
    localparam logic [16:0] SLTU_OPCODE    = 17'h00025;
    localparam logic [16:0] NOR_OPCODE     = 17'h00028;
    localparam logic [16:0] AND_OPCODE     = 17'h00029;
    localparam logic [16:0] OR_OPCODE      = 17'h0002a;
    localparam logic [16:0] XOR_OPCODE     = 17'h0002b;
    localparam logic [16:0] SLLW_OPCODE    = 17'h0002e;
    localparam logic [16:0] SRLW_OPCODE    = 17'h0002f;
    localparam logic [16:0] SRAW_OPCODE    = 17'h00030;
    localparam logic [16:0] MULW_OPCODE    = 17'h00038;
    localparam logic [16:0] MULHW_OPCODE   = 17'h00039;
    localparam logic [16:0] MULHWU_OPCODE  = 17'h0003a;
    localparam logic [16:0] DIVW_OPCODE    = 17'h00040;
    localparam logic [16:0] MODW_OPCODE    = 17'h00041;
    localparam logic [16:0] DIVWU_OPCODE   = 17'h00042;
    localparam logic [16:0] MODWU_OPCODE   = 17'h00043;
    localparam logic [16:0] SLLIW_OPCODE   = 17'h00081;
    localparam logic [16:0] SRLIW_OPCODE   = 17'h00089;
    localparam logic [16:0] SRAIW_OPCODE   = 17'h00091;
    localparam logic [16:0] BREAK_OPCODE   = 17'h00054;
    localparam logic [16:0] SYSCALL_OPCODE = 17'h00056;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] SLTI_OPCODE  = 10'h008;
    localparam logic [9:0] SLTUI_OPCODE = 10'h009;
    localparam logic [9:0] ADDIW_OPCODE = 10'h00a;
    localparam logic [9:0] ANDI_OPCODE  = 10'h00d;
    localparam logic [9:0] ORI_OPCODE   = 10'h00e;
    localparam logic [9:0] XORI_OPCODE  = 10'h00f;

    // 1RI20 opcodes, inst[31:25]
    localparam logic [6:0] LU12IW_OPCODE    = 7'h0a;
    localparam logic [6:0] PCADDU12I_OPCODE = 7'h0e;

    localparam logic [ALU_WIDTH-1:0] ALU_NOP       = 8'h00;
    localparam logic [ALU_WIDTH-1:0] ALU_ADDW      = 8'h01;
    localparam logic [ALU_WIDTH-1:0] ALU_SUBW      = 8'h02;
    localparam logic [ALU_WIDTH-1:0] ALU_SLT       = 8'h03;
    localparam logic [ALU_WIDTH-1:0] ALU_SLTU      = 8'h04;
    localparam logic [ALU_WIDTH-1:0] ALU_NOR       = 8'h05;
    localparam logic [ALU_WIDTH-1:0] ALU_AND       = 8'h06;
    localparam logic [ALU_WIDTH-1:0] ALU_OR        = 8'h07;
    localparam logic [ALU_WIDTH-1:0] ALU_XOR       = 8'h08;
    localparam logic [ALU_WIDTH-1:0] ALU_SLLW      = 8'h09;
    localparam logic [ALU_WIDTH-1:0] ALU_SRLW      = 8'h0a;
    localparam logic [ALU_WIDTH-1:0] ALU_SRAW      = 8'h0b;
    localparam logic [ALU_WIDTH-1:0] ALU_MULW      = 8'h0c;
    localparam logic [ALU_WIDTH-1:0] ALU_MULHW     = 8'h0d;
    localparam logic [ALU_WIDTH-1:0] ALU_MULHWU    = 8'h0e;
    localparam logic [ALU_WIDTH-1:0] ALU_DIVW      = 8'h0f;
    localparam logic [ALU_WIDTH-1:0] ALU_MODW      = 8'h10;
    localparam logic [ALU_WIDTH-1:0] ALU_DIVWU     = 8'h11;
    localparam logic [ALU_WIDTH-1:0] ALU_MODWU     = 8'h12;
    localparam logic [ALU_WIDTH-1:0] ALU_SLLIW     = 8'h13;
    localparam logic [ALU_WIDTH-1:0] ALU_SRLIW     = 8'h14;
    localparam logic [ALU_WIDTH-1:0] ALU_SRAIW     = 8'h15;
    localparam logic [ALU_WIDTH-1:0] ALU_BREAK     = 8'h16;
    localparam logic [ALU_WIDTH-1:0] ALU_SYSCALL   = 8'h17;
    localparam logic [ALU_WIDTH-1:0] ALU_SLTI      = 8'h18;
    localparam logic [ALU_WIDTH-1:0] ALU_SLTUI     = 8'h19;
    localparam logic [ALU_WIDTH-1:0] ALU_ANDI      = 8'h1a;
    localparam logic [ALU_WIDTH-1:0] ALU_ORI       = 8'h1b;
    localparam logic [ALU_WIDTH-1:0] ALU_XORI      = 8'h1c;
    localparam logic [ALU_WIDTH-1:0] ALU_ADDIW     = 8'h1d;
    localparam logic [ALU_WIDTH-1:0] ALU_LU12I     = 8'h1e;
    localparam logic [ALU_WIDTH-1:0] ALU_PCADDU12I = 8'h1f;

    localparam logic [ALU_SEL_WIDTH-1:0] ALU_SEL_NOP        = 3'd0;
    localparam logic [ALU_SEL_WIDTH-1:0] ALU_SEL_ARITHMETIC = 3'd1;
    localparam logic [ALU_SEL_WIDTH-1:0] ALU_SEL_MUL        = 3'd2;
    localparam logic [ALU_SEL_WIDTH-1:0] ALU_SEL_DIV        = 3'd3;

    localparam logic [EXC_CAUSE_WIDTH-1:0] EXCEPTION_SYS = 6'h0b;
    localparam logic [EXC_CAUSE_WIDTH-1:0] EXCEPTION_BRK = 6'h0c;
    localparam logic [EXC_CAUSE_WIDTH-1:0] EXCEPTION_INE = 6'h0d;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] si20;
            logic [4:0]  rd;
        } ri20;
    } inst_word_u;

endpackage

/* hdl/dec_if.sv */
`timescale 1ns/1ps

interface dec_if;

    logic                                     hit;
    logic [la_decode_pkg::ALU_WIDTH-1:0]       aluop;
    logic [la_decode_pkg::ALU_SEL_WIDTH-1:0]   alusel;
    logic                                     reg_write_en;
    logic [4:0]                               reg_write_addr;
    logic [1:0]                               reg_read_en;    // [0] rj port, [1] rk port
    logic [4:0]                               reg_read_addr0;
    logic [4:0]                               reg_read_addr1;
    logic [31:0]                              imm;
    logic                                     exc;
    logic [la_decode_pkg::EXC_CAUSE_WIDTH-1:0] exc_cause;

    modport dec (
        output hit, aluop, alusel, reg_write_en, reg_write_addr, reg_read_en,
        output reg_read_addr0, reg_read_addr1, imm, exc, exc_cause
    );

    modport sel (
        input hit, aluop, alusel, reg_write_en, reg_write_addr, reg_read_en,
        input reg_read_addr0, reg_read_addr1, imm, exc, exc_cause
    );

endinterface

/* hdl/decoder_3r.sv */
`timescale 1ns/1ps

module decoder_3r (
    input  la_decode_pkg::inst_word_u inst_i,
    dec_if.dec                        dec_o
);

    always_comb begin
        // Register-register ALU op unless a case says otherwise
        dec_o.hit            = 1'b1;
        dec_o.aluop          = la_decode_pkg::ALU_NOP;
        dec_o.alusel         = la_decode_pkg::ALU_SEL_ARITHMETIC;
        dec_o.reg_write_en   = 1'b1;
        dec_o.reg_write_addr = inst_i.r3.rd;
        dec_o.reg_read_en    = 2'b11;
        dec_o.reg_read_addr0 = inst_i.r3.rj;
        dec_o.reg_read_addr1 = inst_i.r3.rk;
        dec_o.imm            = 32'b0;
        dec_o.exc            = 1'b0;
        dec_o.exc_cause      = '0;

        case (inst_i.r3.opcode)
            la_decode_pkg::ADDW_OPCODE: dec_o.aluop = la_decode_pkg::ALU_ADDW;
            la_decode_pkg::SUBW_OPCODE: dec_o.aluop = la_decode_pkg::ALU_SUBW;
            la_decode_pkg::SLT_OPCODE:  dec_o.aluop = la_decode_pkg::ALU_SLT;
            la_decode_pkg::SLTU_OPCODE: dec_o.aluop = la_decode_pkg::ALU_SLTU;
            la_decode_pkg::NOR_OPCODE:  dec_o.aluop = la_decode_pkg::ALU_NOR;
            la_decode_pkg::AND_OPCODE:  dec_o.aluop = la_decode_pkg::ALU_AND;
            la_decode_pkg::OR_OPCODE:   dec_o.aluop = la_decode_pkg::ALU_OR;
            la_decode_pkg::XOR_OPCODE:  dec_o.aluop = la_decode_pkg::ALU_XOR;
            la_decode_pkg::SLLW_OPCODE: dec_o.aluop = la_decode_pkg::ALU_SLLW;
            la_decode_pkg::SRLW_OPCODE: dec_o.aluop = la_decode_pkg::ALU_SRLW;
            la_decode_pkg::SRAW_OPCODE: dec_o.aluop = la_decode_pkg::ALU_SRAW;
            la_decode_pkg::MULW_OPCODE, la_decode_pkg::MULHW_OPCODE,
            la_decode_pkg::MULHWU_OPCODE: begin
                dec_o.alusel = la_decode_pkg::ALU_SEL_MUL;
                dec_o.aluop  = (inst_i.r3.opcode == la_decode_pkg::MULW_OPCODE)
                             ? la_decode_pkg::ALU_MULW
                             : (inst_i.r3.opcode == la_decode_pkg::MULHW_OPCODE)
                             ? la_decode_pkg::ALU_MULHW : la_decode_pkg::ALU_MULHWU;
            end
            la_decode_pkg::DIVW_OPCODE, la_decode_pkg::MODW_OPCODE,
            la_decode_pkg::DIVWU_OPCODE, la_decode_pkg::MODWU_OPCODE: begin
                dec_o.alusel = la_decode_pkg::ALU_SEL_DIV;
                case (inst_i.r3.opcode[1:0])   // low bits pick div/mod and signedness
                    2'b00:   dec_o.aluop = la_decode_pkg::ALU_DIVW;
                    2'b01:   dec_o.aluop = la_decode_pkg::ALU_MODW;
                    2'b10:   dec_o.aluop = la_decode_pkg::ALU_DIVWU;
                    default: dec_o.aluop = la_decode_pkg::ALU_MODWU;
                endcase
            end
            la_decode_pkg::SLLIW_OPCODE, la_decode_pkg::SRLIW_OPCODE,
            la_decode_pkg::SRAIW_OPCODE: begin
                dec_o.reg_read_en = 2'b01;              // rk field is ui5 here
                dec_o.imm         = {27'b0, inst_i.r3.rk};
                dec_o.aluop       = (inst_i.r3.opcode == la_decode_pkg::SLLIW_OPCODE)
                                  ? la_decode_pkg::ALU_SLLIW
                                  : (inst_i.r3.opcode == la_decode_pkg::SRLIW_OPCODE)
                                  ? la_decode_pkg::ALU_SRLIW : la_decode_pkg::ALU_SRAIW;
            end
            la_decode_pkg::BREAK_OPCODE, la_decode_pkg::SYSCALL_OPCODE: begin
                dec_o.alusel         = la_decode_pkg::ALU_SEL_NOP;
                dec_o.reg_write_en   = 1'b0;
                dec_o.reg_write_addr = 5'b0;
                dec_o.reg_read_en    = 2'b00;
                dec_o.exc            = 1'b1;
                if (inst_i.r3.opcode == la_decode_pkg::BREAK_OPCODE) begin
                    dec_o.aluop     = la_decode_pkg::ALU_BREAK;
                    dec_o.exc_cause = la_decode_pkg::EXCEPTION_BRK;
                end else begin
                    dec_o.aluop     = la_decode_pkg::ALU_SYSCALL;
                    dec_o.exc_cause = la_decode_pkg::EXCEPTION_SYS;
                end
            end
            default: begin
                dec_o.hit            = 1'b0;
                dec_o.alusel         = la_decode_pkg::ALU_SEL_NOP;
                dec_o.reg_write_en   = 1'b0;
                dec_o.reg_write_addr = 5'b0;
                dec_o.reg_read_en    = 2'b00;
            end
        endcase
    end

endmodule

/* hdl/decoder_2ri12.sv */
`timescale 1ns/1ps

module decoder_2ri12 (
    input  la_decode_pkg::inst_word_u inst_i,
    dec_if.dec                        dec_o
);

    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign imm_sext = {{20{inst_i.ri12.si12[11]}}, inst_i.ri12.si12};
    assign imm_zext = {20'b0, inst_i.ri12.si12};

    always_comb begin
        dec_o.hit            = 1'b1;
        dec_o.aluop          = la_decode_pkg::ALU_NOP;
        dec_o.alusel         = la_decode_pkg::ALU_SEL_ARITHMETIC;
        dec_o.reg_write_en   = 1'b1;
        dec_o.reg_write_addr = inst_i.ri12.rd;
        dec_o.reg_read_en    = 2'b01;
        dec_o.reg_read_addr0 = inst_i.ri12.rj;
        dec_o.reg_read_addr1 = inst_i.r3.rk;
        dec_o.imm            = imm_sext;
        dec_o.exc            = 1'b0;
        dec_o.exc_cause      = '0;

        case (inst_i.ri12.opcode)
            la_decode_pkg::ADDIW_OPCODE: dec_o.aluop = la_decode_pkg::ALU_ADDIW;
            la_decode_pkg::SLTI_OPCODE:  dec_o.aluop = la_decode_pkg::ALU_SLTI;
            la_decode_pkg::SLTUI_OPCODE: dec_o.aluop = la_decode_pkg::ALU_SLTUI;
            la_decode_pkg::ANDI_OPCODE: begin
                dec_o.aluop = la_decode_pkg::ALU_ANDI;
                dec_o.imm   = imm_zext;   // Logic ops take ui12
            end
            la_decode_pkg::ORI_OPCODE: begin
                dec_o.aluop = la_decode_pkg::ALU_ORI;
                dec_o.imm   = imm_zext;
            end
            la_decode_pkg::XORI_OPCODE: begin
                dec_o.aluop = la_decode_pkg::ALU_XORI;
                dec_o.imm   = imm_zext;
            end
            default: begin
                dec_o.hit            = 1'b0;
                dec_o.alusel         = la_decode_pkg::ALU_SEL_NOP;
                dec_o.reg_write_en   = 1'b0;
                dec_o.reg_write_addr = 5'b0;
                dec_o.reg_read_en    = 2'b00;
                dec_o.imm            = 32'b0;
            end
        endcase
    end

endmodule

/* hdl/decoder_1ri20.sv */
`timescale 1ns/1ps

module decoder_1ri20 (
    input  la_decode_pkg::inst_word_u inst_i,
    dec_if.dec                        dec_o
);

    logic is_lu12i;
    logic is_pcaddu12i;

    assign is_lu12i     = (inst_i.ri20.opcode == la_decode_pkg::LU12IW_OPCODE);
    assign is_pcaddu12i = (inst_i.ri20.opcode == la_decode_pkg::PCADDU12I_OPCODE);

    assign dec_o.hit            = is_lu12i | is_pcaddu12i;
    assign dec_o.aluop          = is_lu12i ? la_decode_pkg::ALU_LU12I
                                : is_pcaddu12i ? la_decode_pkg::ALU_PCADDU12I
                                : la_decode_pkg::ALU_NOP;
    assign dec_o.alusel         = dec_o.hit ? la_decode_pkg::ALU_SEL_ARITHMETIC
                                            : la_decode_pkg::ALU_SEL_NOP;
    assign dec_o.reg_write_en   = dec_o.hit;
    assign dec_o.reg_write_addr = dec_o.hit ? inst_i.ri20.rd : 5'b0;
    assign dec_o.reg_read_en    = 2'b00;               // No source registers
    assign dec_o.reg_read_addr0 = inst_i.r3.rj;
    assign dec_o.reg_read_addr1 = 5'b0;
    assign dec_o.imm            = dec_o.hit ? {inst_i.ri20.si20, 12'b0} : 32'b0;
    assign dec_o.exc            = 1'b0;
    assign dec_o.exc_cause      = '0;

endmodule

/* hdl/decode_select.sv */
`timescale 1ns/1ps

module decode_select (
    dec_if.sel                                       d3r_i,
    dec_if.sel                                       d2ri12_i,
    dec_if.sel                                       d1ri20_i,
    input  logic                                     fetch_exc_i,
    input  logic [la_decode_pkg::EXC_CAUSE_WIDTH-1:0] fetch_exc_cause_i,
    dec_if.dec                                       res_o
);

    logic                                     win_exc;
    logic [la_decode_pkg::EXC_CAUSE_WIDTH-1:0] win_cause;
    logic                                     any_hit;

    assign any_hit   = d3r_i.hit | d2ri12_i.hit | d1ri20_i.hit;
    assign res_o.hit = any_hit;

    always_comb begin
        // Hits are exclusive by opcode; 3R also supplies the no-hit defaults
        if (d2ri12_i.hit) begin
            res_o.aluop          = d2ri12_i.aluop;
            res_o.alusel         = d2ri12_i.alusel;
            res_o.reg_write_en   = d2ri12_i.reg_write_en;
            res_o.reg_write_addr = d2ri12_i.reg_write_addr;
            res_o.reg_read_en    = d2ri12_i.reg_read_en;
            res_o.reg_read_addr0 = d2ri12_i.reg_read_addr0;
            res_o.reg_read_addr1 = d2ri12_i.reg_read_addr1;
            res_o.imm            = d2ri12_i.imm;
            win_exc              = d2ri12_i.exc;
            win_cause            = d2ri12_i.exc_cause;
        end else if (d1ri20_i.hit) begin
            res_o.aluop          = d1ri20_i.aluop;
            res_o.alusel         = d1ri20_i.alusel;
            res_o.reg_write_en   = d1ri20_i.reg_write_en;
            res_o.reg_write_addr = d1ri20_i.reg_write_addr;
            res_o.reg_read_en    = d1ri20_i.reg_read_en;
            res_o.reg_read_addr0 = d1ri20_i.reg_read_addr0;
            res_o.reg_read_addr1 = d1ri20_i.reg_read_addr1;
            res_o.imm            = d1ri20_i.imm;
            win_exc              = d1ri20_i.exc;
            win_cause            = d1ri20_i.exc_cause;
        end else begin
            res_o.aluop          = d3r_i.aluop;
            res_o.alusel         = d3r_i.alusel;
            res_o.reg_write_en   = d3r_i.reg_write_en;
            res_o.reg_write_addr = d3r_i.reg_write_addr;
            res_o.reg_read_en    = d3r_i.reg_read_en;
            res_o.reg_read_addr0 = d3r_i.reg_read_addr0;
            res_o.reg_read_addr1 = d3r_i.reg_read_addr1;
            res_o.imm            = d3r_i.imm;
            win_exc              = d3r_i.exc;
            win_cause            = d3r_i.exc_cause;
        end

        // Fetch fault beats decode fault beats INE
        res_o.exc       = fetch_exc_i | win_exc | ~any_hit;
        res_o.exc_cause = fetch_exc_i ? fetch_exc_cause_i
                        : win_exc ? win_cause
                        : ~any_hit ? la_decode_pkg::EXCEPTION_INE : '0;

        if (res_o.exc) begin
            res_o.reg_write_en = 1'b0;
            res_o.reg_read_en  = 2'b00;
        end
    end

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic                                       valid_i,
    input  logic [31:0]                                pc_i,
    input  logic [31:0]                                inst_i,
    input  logic                                       fetch_exc_i,
    input  logic [la_decode_pkg::EXC_CAUSE_WIDTH-1:0]   fetch_exc_cause_i,
    input  logic                                       stall_i,
    input  logic                                       flush_i,
    output logic                                       valid_o,
    output logic [31:0]                                pc_o,
    output logic [la_decode_pkg::ALU_WIDTH-1:0]         aluop_o,
    output logic [la_decode_pkg::ALU_SEL_WIDTH-1:0]     alusel_o,
    output logic                                       reg_write_en_o,
    output logic [4:0]                                 reg_write_addr_o,
    output logic [1:0]                                 reg_read_en_o,
    output logic [4:0]                                 reg_read_addr0_o,
    output logic [4:0]                                 reg_read_addr1_o,
    output logic [31:0]                                imm_o,
    output logic                                       exc_o,
    output logic [la_decode_pkg::EXC_CAUSE_WIDTH-1:0]   exc_cause_o
);

    la_decode_pkg::inst_word_u inst_w;

    dec_if d3r ();
    dec_if d2ri12 ();
    dec_if d1ri20 ();
    dec_if res ();

    assign inst_w = inst_i;

    decoder_3r    u_dec_3r    (.inst_i(inst_w), .dec_o(d3r));
    decoder_2ri12 u_dec_2ri12 (.inst_i(inst_w), .dec_o(d2ri12));
    decoder_1ri20 u_dec_1ri20 (.inst_i(inst_w), .dec_o(d1ri20));

    decode_select u_select (
        .d3r_i             (d3r),
        .d2ri12_i          (d2ri12),
        .d1ri20_i          (d1ri20),
        .fetch_exc_i       (fetch_exc_i),
        .fetch_exc_cause_i (fetch_exc_cause_i),
        .res_o             (res)
    );

    // Dispatch slot register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o          <= 1'b0;
            pc_o             <= 32'b0;
            aluop_o          <= '0;
            alusel_o         <= '0;
            reg_write_en_o   <= 1'b0;
            reg_write_addr_o <= 5'b0;
            reg_read_en_o    <= 2'b00;
            reg_read_addr0_o <= 5'b0;
            reg_read_addr1_o <= 5'b0;
            imm_o            <= 32'b0;
            exc_o            <= 1'b0;
            exc_cause_o      <= '0;
        end else if (flush_i) begin
            valid_o <= 1'b0;           // wins over stall
        end else if (!stall_i) begin
            valid_o          <= valid_i;
            pc_o             <= pc_i;
            aluop_o          <= res.aluop;
            alusel_o         <= res.alusel;
            reg_write_en_o   <= res.reg_write_en;
            reg_write_addr_o <= res.reg_write_addr;
            reg_read_en_o    <= res.reg_read_en;
            reg_read_addr0_o <= res.reg_read_addr0;
            reg_read_addr1_o <= res.reg_read_addr1;
            imm_o            <= res.imm;
            exc_o            <= res.exc;
            exc_cause_o      <= res.exc_cause;
        end
    end

endmodule

/* test/id_stage_asserts.sv */
`timescale 1ns/1ps

module id_stage_asserts (
    input logic         clk,
    input logic         rst_n_i,
    input logic         stall_i,
    input logic         flush_i,
    input logic         slot_valid_i,
    input logic         slot_exc_i,
    input logic         slot_write_en_i,
    input logic [100:0] slot_i           // All dispatch outputs, valid_o first
);

    property reset_clears_p;
        @(posedge clk) !rst_n_i |=> (!slot_valid_i && !slot_exc_i);
    endproperty

    property exc_blocks_write_p;
        @(posedge clk) disable iff (!rst_n_i) slot_exc_i |-> !slot_write_en_i;
    endproperty

    // Stall without flush keeps the whole slot
    property stall_holds_p;
        @(posedge clk) disable iff (!rst_n_i) (stall_i && !flush_i) |=> $stable(slot_i);
    endproperty

    reset_clears_a: assert property (reset_clears_p)
        else $error("valid_o or exc_o high in the cycle after reset");
    exc_blocks_write_a: assert property (exc_blocks_write_p)
        else $error("reg_write_en_o high while exc_o is set");
    stall_holds_a: assert property (stall_holds_p)
        else $error("dispatch outputs changed during a stall");

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .stall_i         (stall_i),
    .flush_i         (flush_i),
    .slot_valid_i    (valid_o),
    .slot_exc_i      (exc_o),
    .slot_write_en_i (reg_write_en_o),
    .slot_i          ({valid_o, pc_o, aluop_o, alusel_o, reg_write_en_o, reg_write_addr_o,
                       reg_read_en_o, reg_read_addr0_o, reg_read_addr1_o, imm_o, exc_o,
                       exc_cause_o})
);

/* test/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int TEST_CYCLES = 2620;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 500) * CLK_PERIOD;

    logic        clk;
    logic        rst_n_i;
    logic        valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic        fetch_exc_i;
    logic [5:0]  fetch_exc_cause_i;
    logic        stall_i;
    logic        flush_i;
    logic        valid_o;
    logic [31:0] pc_o;
    logic [7:0]  aluop_o;
    logic [2:0]  alusel_o;
    logic        reg_write_en_o;
    logic [4:0]  reg_write_addr_o;
    logic [1:0]  reg_read_en_o;
    logic [4:0]  reg_read_addr0_o;
    logic [4:0]  reg_read_addr1_o;
    logic [31:0] imm_o;
    logic        exc_o;
    logic [5:0]  exc_cause_o;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;

    logic [100:0] exp_state;             // {valid, pc, decoded fields}
    logic [100:0] exp_q [$];
    logic         e_valid, e_we, e_exc;
    logic [31:0]  e_pc, e_imm;
    logic [7:0]   e_aluop;
    logic [2:0]   e_alusel;
    logic [4:0]   e_wa, e_ra0, e_ra1;
    logic [1:0]   e_re;
    logic [5:0]   e_cause;

    // 0..10 reg-reg, 11..13 mul, 14..17 div, 18..20 imm shifts, 21 break, 22 syscall
    logic [16:0] op3r_tab [0:22] = '{
        la_decode_pkg::ADDW_OPCODE, la_decode_pkg::SUBW_OPCODE, la_decode_pkg::SLT_OPCODE,
        la_decode_pkg::SLTU_OPCODE, la_decode_pkg::NOR_OPCODE, la_decode_pkg::AND_OPCODE,
        la_decode_pkg::OR_OPCODE, la_decode_pkg::XOR_OPCODE, la_decode_pkg::SLLW_OPCODE,
        la_decode_pkg::SRLW_OPCODE, la_decode_pkg::SRAW_OPCODE, la_decode_pkg::MULW_OPCODE,
        la_decode_pkg::MULHW_OPCODE, la_decode_pkg::MULHWU_OPCODE, la_decode_pkg::DIVW_OPCODE,
        la_decode_pkg::MODW_OPCODE, la_decode_pkg::DIVWU_OPCODE, la_decode_pkg::MODWU_OPCODE,
        la_decode_pkg::SLLIW_OPCODE, la_decode_pkg::SRLIW_OPCODE, la_decode_pkg::SRAIW_OPCODE,
        la_decode_pkg::BREAK_OPCODE, la_decode_pkg::SYSCALL_OPCODE};
    logic [7:0] alu3r_tab [0:22] = '{
        la_decode_pkg::ALU_ADDW, la_decode_pkg::ALU_SUBW, la_decode_pkg::ALU_SLT,
        la_decode_pkg::ALU_SLTU, la_decode_pkg::ALU_NOR, la_decode_pkg::ALU_AND,
        la_decode_pkg::ALU_OR, la_decode_pkg::ALU_XOR, la_decode_pkg::ALU_SLLW,
        la_decode_pkg::ALU_SRLW, la_decode_pkg::ALU_SRAW, la_decode_pkg::ALU_MULW,
        la_decode_pkg::ALU_MULHW, la_decode_pkg::ALU_MULHWU, la_decode_pkg::ALU_DIVW,
        la_decode_pkg::ALU_MODW, la_decode_pkg::ALU_DIVWU, la_decode_pkg::ALU_MODWU,
        la_decode_pkg::ALU_SLLIW, la_decode_pkg::ALU_SRLIW, la_decode_pkg::ALU_SRAIW,
        la_decode_pkg::ALU_BREAK, la_decode_pkg::ALU_SYSCALL};
    // First three sign-extend si12
    logic [9:0] op12_tab [0:5] = '{
        la_decode_pkg::ADDIW_OPCODE, la_decode_pkg::SLTI_OPCODE, la_decode_pkg::SLTUI_OPCODE,
        la_decode_pkg::ANDI_OPCODE, la_decode_pkg::ORI_OPCODE, la_decode_pkg::XORI_OPCODE};
    logic [7:0] alu12_tab [0:5] = '{
        la_decode_pkg::ALU_ADDIW, la_decode_pkg::ALU_SLTI, la_decode_pkg::ALU_SLTUI,
        la_decode_pkg::ALU_ANDI, la_decode_pkg::ALU_ORI, la_decode_pkg::ALU_XORI};
    logic [6:0] op20_tab [0:1] = '{la_decode_pkg::LU12IW_OPCODE, la_decode_pkg::PCADDU12I_OPCODE};
    logic [7:0] alu20_tab [0:1] = '{la_decode_pkg::ALU_LU12I, la_decode_pkg::ALU_PCADDU12I};

    id_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic one_in(input int n);
        return pick(n) == 0;
    endfunction

    // Kind 0 3R, 1 2RI12, 2 1RI20, 3 raw random, 4 any of these
    function automatic logic [31:0] make_word(input int kind);
        logic [31:0] r;
        int          k;
        r = $random(seed);
        k = (kind == 4) ? pick(4) : kind;
        case (k)
            0:       return {op3r_tab[pick(23)], r[14:0]};
            1:       return {op12_tab[pick(6)], r[21:0]};
            2:       return {op20_tab[pick(2)], r[24:0]};
            default: return r;
        endcase
    endfunction

    // Decoded fields {aluop, alusel, we, wa, re, ra0, ra1, imm, exc, cause}
    function automatic logic [67:0] decode_model(input logic [31:0] w, input logic fexc,
                                                 input logic [5:0] fcause);
        logic [7:0]  op;
        logic [2:0]  sel;
        logic        we;
        logic [4:0]  wa;
        logic [1:0]  re;
        logic [4:0]  ra1;
        logic [31:0] imm;
        logic        exc;
        logic [5:0]  cause;
        int          i;
        op    = la_decode_pkg::ALU_NOP;     // Unknown word until a table entry matches
        sel   = la_decode_pkg::ALU_SEL_NOP;
        we    = 1'b0;
        wa    = 5'd0;
        re    = 2'b00;
        ra1   = w[14:10];
        imm   = 32'd0;
        exc   = 1'b1;
        cause = la_decode_pkg::EXCEPTION_INE;
        for (i = 0; i < 23; i++) begin
            if (w[31:15] == op3r_tab[i]) begin
                op = alu3r_tab[i];
                if (i >= 21) begin
                    cause = (i == 21) ? la_decode_pkg::EXCEPTION_BRK
                                      : la_decode_pkg::EXCEPTION_SYS;
                end else begin
                    sel   = (i >= 14 && i < 18) ? la_decode_pkg::ALU_SEL_DIV
                          : (i >= 11 && i < 14) ? la_decode_pkg::ALU_SEL_MUL
                          : la_decode_pkg::ALU_SEL_ARITHMETIC;
                    we    = 1'b1;
                    wa    = w[4:0];
                    re    = (i < 18) ? 2'b11 : 2'b01;
                    imm   = (i < 18) ? 32'd0 : {27'd0, w[14:10]};
                    exc   = 1'b0;
                    cause = 6'd0;
                end
            end
        end
        for (i = 0; i < 6; i++) begin
            if (w[31:22] == op12_tab[i]) begin
                op    = alu12_tab[i];
                sel   = la_decode_pkg::ALU_SEL_ARITHMETIC;
                we    = 1'b1;
                wa    = w[4:0];
                re    = 2'b01;
                imm   = (i < 3) ? {{20{w[21]}}, w[21:10]} : {20'd0, w[21:10]};
                exc   = 1'b0;
                cause = 6'd0;
            end
        end
        for (i = 0; i < 2; i++) begin
            if (w[31:25] == op20_tab[i]) begin
                op    = alu20_tab[i];
                sel   = la_decode_pkg::ALU_SEL_ARITHMETIC;
                we    = 1'b1;
                wa    = w[4:0];
                ra1   = 5'd0;
                imm   = {w[24:5], 12'd0};
                exc   = 1'b0;
                cause = 6'd0;
            end
        end
        if (fexc) begin
            exc   = 1'b1;
            cause = fcause;
        end
        if (exc) begin
            we = 1'b0;
            re = 2'b00;
        end
        return {op, sel, we, wa, re, w[9:5], ra1, imm, exc, cause};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Model of the dispatch register, one entry per edge
    always @(posedge clk) begin
        if (!rst_n_i)
            exp_state = '0;
        else if (flush_i)
            exp_state[100] = 1'b0;
        else if (!stall_i)
            exp_state = {valid_i, pc_i, decode_model(inst_i, fetch_exc_i, fetch_exc_cause_i)};
        exp_q.push_back(exp_state);
    end

    always @(negedge clk) begin
        if (exp_q.size() > 0) begin
            {e_valid, e_pc, e_aluop, e_alusel, e_we, e_wa, e_re, e_ra0, e_ra1, e_imm, e_exc,
             e_cause} = exp_q.pop_front();
            check("valid_o", 32'(e_valid), 32'(valid_o));
            check("pc_o", e_pc, pc_o);
            check("aluop_o", 32'(e_aluop), 32'(aluop_o));
            check("alusel_o", 32'(e_alusel), 32'(alusel_o));
            check("reg_write_en_o", 32'(e_we), 32'(reg_write_en_o));
            check("reg_write_addr_o", 32'(e_wa), 32'(reg_write_addr_o));
            check("reg_read_en_o", 32'(e_re), 32'(reg_read_en_o));
            check("reg_read_addr0_o", 32'(e_ra0), 32'(reg_read_addr0_o));
            check("reg_read_addr1_o", 32'(e_ra1), 32'(reg_read_addr1_o));
            check("imm_o", e_imm, imm_o);
            check("exc_o", 32'(e_exc), 32'(exc_o));
            check("exc_cause_o", 32'(e_cause), 32'(exc_cause_o));
        end
    end

    task automatic drive(input logic v, input logic [31:0] w, input logic fexc,
                         input logic st, input logic fl);
        @(posedge clk);
        valid_i           <= v;
        pc_i              <= $random(seed);
        inst_i            <= w;
        fetch_exc_i       <= fexc;
        fetch_exc_cause_i <= 6'($random(seed));
        stall_i           <= st;
        flush_i           <= fl;
    endtask

    // Lets the last driven word reach the outputs and be compared
    task automatic end_test(input string name, input int start);
        @(posedge clk);
        @(negedge clk);
        #1;                          // After the falling-edge compare
        tests++;
        $display("Test %s finished with %0d errors", name, errors - start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int start;
        int i;
        seed              = 32'ha5cacbed;
        rst_n_i           = 1'b0;
        valid_i           = 1'b0;
        pc_i              = 32'd0;
        inst_i            = 32'd0;
        fetch_exc_i       = 1'b0;
        fetch_exc_cause_i = 6'd0;
        stall_i           = 1'b0;
        flush_i           = 1'b0;

        start = errors;
        repeat (8) drive(1'b0, 32'd0, 1'b0, 1'b0, 1'b0);
        rst_n_i <= 1'b1;
        repeat (4) drive(1'b0, 32'd0, 1'b0, 1'b0, 1'b0);
        end_test("reset", start);

        start = errors;
        for (i = 0; i < 23; i++) begin
            repeat (4) drive(1'b1, {op3r_tab[i], 15'($random(seed))}, 1'b0, 1'b0, 1'b0);
        end
        end_test("3r_opcodes", start);

        start = errors;
        repeat (200) drive(1'b1, make_word(1 + pick(2)), 1'b0, 1'b0, 1'b0);
        end_test("immediates", start);

        start = errors;
        drive(1'b1, {la_decode_pkg::BREAK_OPCODE, 15'($random(seed))}, 1'b0, 1'b0, 1'b0);
        drive(1'b1, {la_decode_pkg::SYSCALL_OPCODE, 15'($random(seed))}, 1'b0, 1'b0, 1'b0);
        repeat (200) drive(1'b1, make_word(3), 1'b0, 1'b0, 1'b0);
        repeat (100) drive(1'b1, make_word(4), 1'b1, 1'b0, 1'b0);   // Fetch fault wins
        end_test("exceptions", start);

        start = errors;
        repeat (2000) drive(!one_in(4), make_word(4), one_in(16), one_in(4), one_in(8));
        end_test("stall_flush", start);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* la_decode.f */
hdl/la_decode_pkg.sv
hdl/dec_if.sv
hdl/decoder_3r.sv
hdl/decoder_2ri12.sv
hdl/decoder_1ri20.sv
hdl/decode_select.sv
hdl/id_stage.sv
test/id_stage_asserts.sv
test/id_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode-stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module id_stage_tb \
    -f la_decode.f \
    -o id_stage_tb

# A failing simulation still prints its output; the grep decides the status
out=$(./obj_dir/id_stage_tb || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS"
